//--- logic/calcPkg.sv
`default_nettype none

package calcPkg;

	// ******************************
	// sizes and timing
	// ******************************
	localparam int maxDigits     = 3;
	localparam int resultDigits  = 6;
	localparam int bcdIterations = 20;
	localparam int uartBitClocks = 8;   // short bit time for simulation

	typedef logic [7:0]  asciiT;
	typedef logic [3:0]  bcdDigitT;
	typedef logic [9:0]  opBinT;        // up to 999
	typedef logic [19:0] resBinT;       // up to 998001
	typedef logic [1:0]  digitCountT;   // digits held by one operand
	typedef logic [$clog2(resultDigits)-1:0]  digitIdxT;
	typedef logic [$clog2(bcdIterations)-1:0] iterCountT;
	typedef logic [$clog2(uartBitClocks)-1:0] bitClkCountT;
	typedef logic [9:0]  uartFrameT;    // start, 8 data, stop
	typedef logic [3:0]  bitIndexT;
	typedef bcdDigitT [resultDigits-1:0] bcdWordT;   // [5] is most significant

	// ******************************
	// key and output characters
	// ******************************
	localparam asciiT keyZero    = "0";
	localparam asciiT keyNine    = "9";
	localparam asciiT keyClear   = "E";
	localparam asciiT keyEquals  = "=";
	localparam asciiT keyPlus    = "+";
	localparam asciiT keyStar    = "*";
	localparam asciiT keyLess    = "<";
	localparam asciiT keyGreater = ">";
	localparam asciiT chCr       = 8'h0D;
	localparam asciiT chLf       = 8'h0A;

	typedef struct packed {
		bcdDigitT hundreds;
		bcdDigitT tens;
		bcdDigitT ones;
	} operandT;

	typedef enum logic [1:0] {opAdd, opMul, opLess, opGreater} opKindT;

	typedef struct packed {
		operandT opA;
		operandT opB;
		opKindT  op;
	} exprT;

	typedef struct packed {
		logic    isBool;
		logic    boolVal;
		bcdWordT digits;
	} resultT;

	typedef enum logic [1:0] {outEcho, outResult, outClear} outKindT;

	typedef struct packed {
		outKindT kind;
		asciiT   ch;
	} outReqT;

	typedef enum logic [1:0] {entA, entOp, entB, entWait} entryStateT;

	typedef enum logic [2:0] {
		seqIdle, seqEcho, seqWaitRes, seqNum, seqBool, seqCr, seqLf, seqDrain
	} seqStateT;

endpackage

`default_nettype wire

//--- logic/binToBcd.sv
`timescale 1ns/1ps
`default_nettype none

module binToBcd (
	input  logic             USER_CLK,
	input  logic             RST,
	input  logic             convStart,
	input  calcPkg::resBinT  binValue,
	output logic             convDone,
	output calcPkg::bcdWordT digits
);
	import calcPkg::*;

	bcdWordT   bcdReg;
	resBinT    binReg;
	bcdWordT   bcdAdj;
	iterCountT iterCount;
	logic      running;

	// add three to every digit of five or more
	always_comb begin
		for (int i = 0; i < resultDigits; i++) begin
			bcdAdj[i] = (bcdReg[i] >= 4'd5) ? bcdReg[i] + 4'd3 : bcdReg[i];
		end
	end

	always_ff @(posedge USER_CLK) begin
		convDone <= 1'b0;
		if (RST) begin
			running   <= 1'b0;
			iterCount <= '0;
		end else if (convStart) begin
			running   <= 1'b1;
			iterCount <= '0;
		end else if (running) begin
			if (iterCount == iterCountT'(bcdIterations - 1)) begin   // last shift
				running  <= 1'b0;
				convDone <= 1'b1;
			end
			iterCount <= iterCount + 1'b1;
		end
	end

	always_ff @(posedge USER_CLK) begin
		if (convStart) begin
			bcdReg <= '0;
			binReg <= binValue;
		end else if (running) begin
			{bcdReg, binReg} <= {bcdAdj, binReg} << 1;   // one bit per cycle
		end
	end

	assign digits = bcdReg;

endmodule

`default_nettype wire

//--- logic/evaluator.sv
`timescale 1ns/1ps
`default_nettype none

module evaluator (
	input  logic           USER_CLK,
	input  logic           RST,
	input  logic           evalStart,
	input  calcPkg::exprT  expr,
	output calcPkg::resultT result,
	output logic           resultValid
);
	import calcPkg::*;

	opBinT   binA;
	opBinT   binB;
	opKindT  opQ;
	logic    calcPend;   // operands registered, result due
	logic    isCompare;
	logic    convStart;
	resBinT  binValue;
	logic    convDone;
	bcdWordT convDigits;

	function automatic opBinT toBin(operandT v);
		return 10'(v.hundreds) * 10'd100 + 10'(v.tens) * 10'd10 + 10'(v.ones);
	endfunction

	assign isCompare = (opQ == opLess) || (opQ == opGreater);
	assign convStart = calcPend && !isCompare;
	assign binValue  = (opQ == opMul) ? resBinT'(binA) * resBinT'(binB)
	                                  : resBinT'(binA) + resBinT'(binB);

	binToBcd conv (
		.USER_CLK (USER_CLK),
		.RST      (RST),
		.convStart(convStart),
		.binValue (binValue),
		.convDone (convDone),
		.digits   (convDigits)
	);

	always_ff @(posedge USER_CLK) begin
		if (RST) begin
			calcPend    <= 1'b0;
			resultValid <= 1'b0;
		end else begin
			calcPend    <= evalStart;
			resultValid <= (calcPend && isCompare) || convDone;
		end
		if (evalStart) begin
			binA <= toBin(expr.opA);
			binB <= toBin(expr.opB);
			opQ  <= expr.op;
		end
		// ******************************
		// result capture
		// ******************************
		if (calcPend && isCompare) begin
			result.isBool  <= 1'b1;
			result.boolVal <= (opQ == opLess) ? (binA < binB) : (binA > binB);   // strict
			result.digits  <= '0;
		end else if (convDone) begin
			result.isBool  <= 1'b0;
			result.boolVal <= 1'b0;
			result.digits  <= convDigits;
		end
	end

endmodule

`default_nettype wire

//--- logic/keyEntry.sv
`timescale 1ns/1ps
`default_nettype none

module keyEntry (
	input  logic              USER_CLK,
	input  logic              RST,
	input  logic              keyStrobe,
	input  calcPkg::asciiT    keyCode,
	input  logic              seqBusy,
	output logic              beep,
	output logic              digitToA,
	output logic              digitToB,
	output logic              setOp,
	output logic              clearAll,
	output calcPkg::bcdDigitT digit,
	output calcPkg::opKindT   op,
	output logic              outValid,
	output calcPkg::outReqT   outReq,
	output logic              evalStart
);
	import calcPkg::*;

	entryStateT state;
	digitCountT countA;
	digitCountT countB;
	logic       seqBusyQ;
	logic       isDigit;
	logic       isOp;
	logic       keyTaken;
	opKindT     keyOp;

	// classify the incoming key
	always_comb begin
		isDigit = (keyCode >= keyZero) && (keyCode <= keyNine);
		isOp    = 1'b1;
		keyOp   = opAdd;
		case (keyCode)
			keyPlus:    keyOp = opAdd;
			keyStar:    keyOp = opMul;
			keyLess:    keyOp = opLess;
			keyGreater: keyOp = opGreater;
			default:    isOp = 1'b0;
		endcase
		keyTaken = keyStrobe && !seqBusy && !outValid && (state != entWait);   // busy keys are lost
	end

	always_ff @(posedge USER_CLK) begin
		beep      <= 1'b0;
		digitToA  <= 1'b0;
		digitToB  <= 1'b0;
		setOp     <= 1'b0;
		clearAll  <= 1'b0;
		outValid  <= 1'b0;
		evalStart <= 1'b0;
		seqBusyQ  <= seqBusy;
		digit     <= keyCode[3:0];   // ascii digit low nibble
		op        <= keyOp;
		outReq    <= '{kind: outEcho, ch: keyCode};
		if (RST) begin
			state    <= entA;
			countA   <= '0;
			countB   <= '0;
			seqBusyQ <= 1'b0;
		end else if (state == entWait) begin
			if (seqBusyQ && !seqBusy) begin   // result fully sent
				clearAll <= 1'b1;
				countA   <= '0;
				countB   <= '0;
				state    <= entA;
			end
		end else if (keyTaken) begin
			if (keyCode == keyClear) begin
				clearAll    <= 1'b1;
				outValid    <= 1'b1;
				outReq.kind <= outClear;
				countA      <= '0;
				countB      <= '0;
				state       <= entA;
			end else begin
				case (state)
					entA: begin
						if (isDigit && (countA < digitCountT'(maxDigits))) begin
							digitToA <= 1'b1;
							outValid <= 1'b1;
							countA   <= countA + 2'd1;
						end else if (isOp && (countA != '0)) begin
							setOp    <= 1'b1;
							outValid <= 1'b1;
							state    <= entOp;
						end else begin
							beep <= 1'b1;
						end
					end
					entOp: begin
						if (isDigit) begin   // first B digit
							digitToB <= 1'b1;
							outValid <= 1'b1;
							countB   <= 2'd1;
							state    <= entB;
						end else begin
							beep <= 1'b1;
						end
					end
					entB: begin
						if (isDigit && (countB < digitCountT'(maxDigits))) begin
							digitToB <= 1'b1;
							outValid <= 1'b1;
							countB   <= countB + 2'd1;
						end else if (keyCode == keyEquals) begin
							outValid    <= 1'b1;
							outReq.kind <= outResult;
							evalStart   <= 1'b1;
							state       <= entWait;
						end else begin
							beep <= 1'b1;
						end
					end
					default: beep <= 1'b1;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/operandRegs.sv
`timescale 1ns/1ps
`default_nettype none

module operandRegs (
	input  logic              USER_CLK,
	input  logic              RST,
	input  logic              digitToA,
	input  logic              digitToB,
	input  logic              setOp,
	input  logic              clearAll,
	input  calcPkg::bcdDigitT digit,
	input  calcPkg::opKindT   op,
	output calcPkg::exprT     expr
);
	import calcPkg::*;

	// new digit enters at ones, older digits move up
	function automatic operandT shiftIn(operandT cur, bcdDigitT d);
		operandT nxt;
		nxt.hundreds = cur.tens;
		nxt.tens     = cur.ones;
		nxt.ones     = d;
		return nxt;
	endfunction

	always_ff @(posedge USER_CLK) begin
		if (RST || clearAll) begin
			expr <= '0;
		end else begin
			if (digitToA) begin
				expr.opA <= shiftIn(expr.opA, digit);
			end
			if (digitToB) begin
				expr.opB <= shiftIn(expr.opB, digit);
			end
			if (setOp) begin
				expr.op <= op;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/outputSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module outputSequencer (
	input  logic            USER_CLK,
	input  logic            RST,
	input  logic            outValid,
	input  calcPkg::outReqT outReq,
	input  logic            resultValid,
	input  calcPkg::resultT result,
	input  logic            txBusy,
	output logic            seqBusy,
	output logic            txStart,
	output calcPkg::asciiT  txByte
);
	import calcPkg::*;

	seqStateT state;
	outReqT   reqQ;
	logic     resultReady;   // result arrived during the echo
	digitIdxT pos;
	digitIdxT leadPos;
	digitIdxT wordLast;
	asciiT    wordChar;
	logic     canSend;

	// highest nonzero digit, ones always sent
	always_comb begin
		leadPos = '0;
		for (int i = 1; i < resultDigits; i++) begin
			if (result.digits[i] != 4'd0) leadPos = digitIdxT'(i);
		end
	end

	always_comb begin
		wordLast = result.boolVal ? digitIdxT'(3) : digitIdxT'(4);
		if (result.boolVal) begin
			case (pos)
				3'd0:    wordChar = "T";
				3'd1:    wordChar = "R";
				3'd2:    wordChar = "U";
				default: wordChar = "E";
			endcase
		end else begin
			case (pos)
				3'd0:    wordChar = "F";
				3'd1:    wordChar = "A";
				3'd2:    wordChar = "L";
				3'd3:    wordChar = "S";
				default: wordChar = "E";
			endcase
		end
	end

	assign canSend = !txBusy && !txStart;   // txBusy lags txStart by a cycle
	assign seqBusy = (state != seqIdle);

	always_ff @(posedge USER_CLK) begin
		txStart <= 1'b0;
		if (RST) begin
			state       <= seqIdle;
			resultReady <= 1'b0;
		end else begin
			if (outValid) resultReady <= 1'b0;
			else if (resultValid) resultReady <= 1'b1;
			case (state)
				seqIdle: begin
					if (outValid) begin
						reqQ  <= outReq;
						state <= seqEcho;
					end
				end
				seqEcho: begin
					if (canSend) begin
						txStart <= 1'b1;
						txByte  <= reqQ.ch;
						case (reqQ.kind)
							outEcho:   state <= seqDrain;
							outResult: state <= seqWaitRes;
							default:   state <= seqCr;
						endcase
					end
				end
				seqWaitRes: begin
					if (resultReady) begin
						pos   <= result.isBool ? '0 : leadPos;
						state <= result.isBool ? seqBool : seqNum;
					end
				end
				seqNum: begin
					if (canSend) begin
						txStart <= 1'b1;
						txByte  <= keyZero | asciiT'(result.digits[pos]);
						if (pos == '0) state <= seqCr;
						else pos <= pos - 1'b1;
					end
				end
				seqBool: begin
					if (canSend) begin
						txStart <= 1'b1;
						txByte  <= wordChar;
						if (pos == wordLast) state <= seqCr;
						else pos <= pos + 1'b1;
					end
				end
				seqCr: begin
					if (canSend) begin
						txStart <= 1'b1;
						txByte  <= chCr;
						state   <= seqLf;
					end
				end
				seqLf: begin
					if (canSend) begin
						txStart <= 1'b1;
						txByte  <= chLf;
						state   <= seqDrain;
					end
				end
				default: begin
					if (canSend) state <= seqIdle;   // last stop bit done
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/uartTx.sv
`timescale 1ns/1ps
`default_nettype none

module uartTx (
	input  logic           USER_CLK,
	input  logic           RST,
	input  logic           txStart,
	input  calcPkg::asciiT txByte,
	output logic           txBusy,
	output logic           serialTx
);
	import calcPkg::*;

	uartFrameT   frame;
	bitClkCountT clkCnt;
	bitIndexT    bitIdx;

	always_ff @(posedge USER_CLK) begin
		if (RST) begin
			txBusy   <= 1'b0;
			serialTx <= 1'b1;   // line idles high
			clkCnt   <= '0;
			bitIdx   <= '0;
		end else if (!txBusy) begin
			if (txStart) begin
				frame    <= {1'b1, txByte, 1'b0};
				serialTx <= 1'b0;   // start bit
				txBusy   <= 1'b1;
				clkCnt   <= '0;
				bitIdx   <= '0;
			end
		end else if (clkCnt == bitClkCountT'(uartBitClocks - 1)) begin
			clkCnt <= '0;
			if (bitIdx == bitIndexT'($bits(uartFrameT) - 1)) begin
				txBusy <= 1'b0;   // end of stop bit
			end else begin
				bitIdx   <= bitIdx + 1'b1;
				serialTx <= frame[1];   // lsb first
				frame    <= {1'b1, frame[9:1]};
			end
		end else begin
			clkCnt <= clkCnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/calcTop.sv
`timescale 1ns/1ps
`default_nettype none

module calcTop (
	input  logic           USER_CLK,
	input  logic           RST,
	input  logic           keyStrobe,
	input  calcPkg::asciiT keyCode,
	output logic           serialTx,
	output logic           beep
);
	import calcPkg::*;

	logic     digitToA;
	logic     digitToB;
	logic     setOp;
	logic     clearAll;
	bcdDigitT digit;
	opKindT   op;
	exprT     expr;
	logic     outValid;
	outReqT   outReq;
	logic     evalStart;
	logic     seqBusy;
	resultT   result;
	logic     resultValid;
	logic     txStart;
	asciiT    txByte;
	logic     txBusy;

	keyEntry entry (
		.USER_CLK(USER_CLK), .RST(RST), .keyStrobe(keyStrobe), .keyCode(keyCode),
		.seqBusy(seqBusy), .beep(beep), .digitToA(digitToA), .digitToB(digitToB),
		.setOp(setOp), .clearAll(clearAll), .digit(digit), .op(op),
		.outValid(outValid), .outReq(outReq), .evalStart(evalStart)
	);

	operandRegs regs (
		.USER_CLK(USER_CLK), .RST(RST), .digitToA(digitToA), .digitToB(digitToB),
		.setOp(setOp), .clearAll(clearAll), .digit(digit), .op(op), .expr(expr)
	);

	evaluator eval (
		.USER_CLK(USER_CLK), .RST(RST), .evalStart(evalStart), .expr(expr),
		.result(result), .resultValid(resultValid)
	);

	outputSequencer seq (
		.USER_CLK(USER_CLK), .RST(RST), .outValid(outValid), .outReq(outReq),
		.resultValid(resultValid), .result(result), .txBusy(txBusy),
		.seqBusy(seqBusy), .txStart(txStart), .txByte(txByte)
	);

	uartTx tx (
		.USER_CLK(USER_CLK), .RST(RST), .txStart(txStart), .txByte(txByte),
		.txBusy(txBusy), .serialTx(serialTx)
	);

endmodule

`default_nettype wire

//--- sim/calcTb.sv
`timescale 1ns/1ps
`default_nettype none

module calcTb;
	import calcPkg::*;

	localparam int     clkNs      = 40;
	localparam int     bitNs      = uartBitClocks * clkNs;
	localparam int     keyBudget  = 220;   // upper bound on keys pressed in the run
	localparam longint watchdogNs = longint'(keyBudget) * 12 * 10 * uartBitClocks * clkNs
	                                + 100000;

	logic  USER_CLK;
	logic  RST;
	logic  keyStrobe;
	asciiT keyCode;
	logic  serialTx;
	logic  beep;
	logic  expectBeep;   // strobe in flight should be rejected

	asciiT rxQ[$];       // bytes seen on the serial line
	asciiT expQ[$];      // bytes the model predicts
	int    passCount;
	int    failCount;
	int    testFailStart;

	// reference entry model
	int    mState;       // 0 operand A, 1 after operator, 2 operand B
	int    cntA;
	int    cntB;
	int    valA;
	int    valB;
	asciiT mOp;

	calcTop dut (
		.USER_CLK (USER_CLK),
		.RST      (RST),
		.keyStrobe(keyStrobe),
		.keyCode  (keyCode),
		.serialTx (serialTx),
		.beep     (beep)
	);

	initial begin
		USER_CLK = 1'b0;
		forever #(clkNs / 2) USER_CLK = ~USER_CLK;
	end

	// ******************************
	// beep checks
	// ******************************
	assert property (@(posedge USER_CLK) disable iff (RST) beep |=> !beep)
		else begin
			$display("Fail t=%0t beep expected 0 got 1 (pulse longer than a cycle)", $time);
			failCount++;
		end

	assert property (@(posedge USER_CLK) disable iff (RST) (keyStrobe && expectBeep) |=> beep)
		else begin
			$display("Fail t=%0t beep expected 1 got 0", $time);
			failCount++;
		end

	assert property (@(posedge USER_CLK) disable iff (RST) beep |-> $past(keyStrobe && expectBeep))
		else begin
			$display("Fail t=%0t beep expected 0 got 1 (no rejected key before it)", $time);
			failCount++;
		end

	// 8N1 receiver sampling at mid bit
	task automatic receiveByte(output asciiT data);
		@(negedge serialTx);
		#(bitNs / 2);
		if (serialTx !== 1'b0) begin
			$display("start bit on serialTx did not stay low at t=%0t", $time);
			failCount++;
		end
		for (int i = 0; i < 8; i++) begin
			#(bitNs);
			data[i] = serialTx;
		end
		#(bitNs);
		if (serialTx !== 1'b1) begin
			$display("no stop bit on serialTx at t=%0t", $time);
			failCount++;
		end
	endtask

	initial begin
		asciiT data;
		wait (RST === 1'b0);
		forever begin
			receiveByte(data);
			rxQ.push_back(data);
		end
	end

	function automatic void resetModel();
		mState = 0;
		cntA   = 0;
		cntB   = 0;
		valA   = 0;
		valB   = 0;
		mOp    = keyPlus;
	endfunction

	function automatic void pushText(string s);
		for (int i = 0; i < s.len(); i++) begin
			expQ.push_back(s[i]);
		end
	endfunction

	function automatic void pushLineEnd();
		expQ.push_back(chCr);
		expQ.push_back(chLf);
	endfunction

	function automatic string resultText();
		logic truth;
		case (mOp)
			keyPlus: return $sformatf("%0d", valA + valB);
			keyStar: return $sformatf("%0d", valA * valB);
			keyLess: truth = (valA < valB);   // strict compare
			default: truth = (valA > valB);
		endcase
		if (truth) begin
			return "TRUE";
		end
		return "FALSE";
	endfunction

	// ******************************
	// reference model of key entry
	// ******************************
	function automatic logic modelKey(asciiT k);
		logic isDigit;
		logic isOp;
		logic rejected;
		isDigit  = (k >= keyZero) && (k <= keyNine);
		isOp     = (k == keyPlus) || (k == keyStar) || (k == keyLess) || (k == keyGreater);
		rejected = 1'b0;
		if (k == keyClear) begin
			expQ.push_back(k);
			pushLineEnd();
			resetModel();
		end else if (mState == 0 && isDigit && cntA < maxDigits) begin
			expQ.push_back(k);
			valA = valA * 10 + int'(k - keyZero);
			cntA++;
		end else if (mState == 0 && isOp && cntA > 0) begin
			expQ.push_back(k);
			mOp    = k;
			mState = 1;
		end else if (mState != 0 && isDigit && cntB < maxDigits) begin
			expQ.push_back(k);
			valB   = valB * 10 + int'(k - keyZero);
			cntB++;
			mState = 2;
		end else if (mState == 2 && k == keyEquals) begin
			expQ.push_back(k);
			pushText(resultText());
			pushLineEnd();
			resetModel();
		end else begin
			rejected = 1'b1;
		end
		return rejected;
	endfunction

	task automatic checkOutput();
		asciiT got;
		asciiT exp;
		while (rxQ.size() > 0) begin
			got = rxQ.pop_front();
			if (expQ.size() == 0) begin
				$display("unexpected byte 0x%h on serialTx at t=%0t", got, $time);
				failCount++;
			end else begin
				exp = expQ.pop_front();
				assert (got == exp) begin
					passCount++;
				end else begin
					$display("Fail t=%0t serialTx expected 0x%h got 0x%h", $time, exp, got);
					failCount++;
				end
			end
		end
		if (expQ.size() != 0) begin
			$display("%0d expected bytes never came on serialTx by t=%0t", expQ.size(), $time);
			failCount++;
			expQ.delete();
		end
	endtask

	task automatic pressKey(asciiT k);
		int waited;
		int limit;
		@(negedge USER_CLK);
		keyStrobe  = 1'b1;
		keyCode    = k;
		expectBeep = modelKey(k);
		@(negedge USER_CLK);
		keyStrobe  = 1'b0;
		expectBeep = 1'b0;
		waited = 0;
		limit  = expQ.size() * 10 * uartBitClocks + 100;
		while (rxQ.size() < expQ.size() && waited < limit) begin
			@(negedge USER_CLK);
			waited++;
		end
		repeat (12 * uartBitClocks) @(negedge USER_CLK);   // room for stray bytes
		checkOutput();
	endtask

	task automatic enterKeys(string s);
		for (int i = 0; i < s.len(); i++) begin
			pressKey(s[i]);
		end
	endtask

	function automatic string randomDigits();
		string s;
		int    n;
		s = "";
		n = $urandom_range(1, maxDigits);
		for (int i = 0; i < n; i++) begin
			s = $sformatf("%s%0d", s, $urandom_range(0, 9));
		end
		return s;
	endfunction

	task automatic reportTest(string name);
		$display("test %s finished, %0d failures", name, failCount - testFailStart);
		testFailStart = failCount;
	endtask

	// ******************************
	// tests
	// ******************************
	initial begin
		void'($urandom(55404));
		RST           = 1'b1;
		keyStrobe     = 1'b0;
		keyCode       = '0;
		expectBeep    = 1'b0;
		passCount     = 0;
		failCount     = 0;
		testFailStart = 0;
		resetModel();
		repeat (16) @(posedge USER_CLK);
		@(negedge USER_CLK);
		RST = 1'b0;
		repeat (4) @(negedge USER_CLK);

		for (int i = 0; i < 6; i++) begin
			enterKeys({randomDigits(), "+", randomDigits(), "="});
		end
		reportTest("addition");

		for (int i = 0; i < 5; i++) begin
			enterKeys({randomDigits(), "*", randomDigits(), "="});
		end
		enterKeys("999*999=");   // largest product
		enterKeys("0*7=");
		reportTest("multiplication");

		enterKeys("12<345=");
		enterKeys("345<12=");
		enterKeys("77<77=");     // equal is false
		enterKeys("12>345=");
		enterKeys("345>12=");
		enterKeys("77>77=");
		reportTest("comparison");

		enterKeys("Q");          // letter
		enterKeys("+");          // operator with no digit yet
		enterKeys("1234");       // fourth digit
		enterKeys("*=");         // equals with no B digit
		enterKeys("<");          // second operator
		enterKeys("56=");
		reportTest("rejected keys");

		enterKeys("E");
		enterKeys("12+3E");
		enterKeys("4*5=");
		enterKeys("7E");
		enterKeys("9>8=");
		reportTest("clear");

		$display("checks passed %0d, checks failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("watchdog fired, the run timed out after %0d ns", watchdogNs);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
logic/calcPkg.sv
logic/binToBcd.sv
logic/evaluator.sv
logic/keyEntry.sv
logic/operandRegs.sv
logic/outputSequencer.sv
logic/uartTx.sv
logic/calcTop.sv
sim/calcTb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module calcTb -o calcSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/calcSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^=== PASS ===$"; then
	exit 0
fi
exit 1
